//--- arm_frontend.f
hdl/arm_frontend_pkg.sv
hdl/arm_fetch.sv
hdl/arm_bl_split.sv
hdl/arm_decode.sv
hdl/arm_frontend.sv
tb/tb_arm_frontend.sv

//--- hdl/arm_bl_split.sv
`default_nettype none

module arm_bl_split (
        // Clock and reset.
        input  wire                          i_clk,
        input  wire                          i_reset,

        // Downstream control.
        input  wire                          i_clear,
        input  wire                          i_stall,

        // Status word, only the T bit matters here.
        input  wire arm_frontend_pkg::word_t i_cpsr,

        // Interrupt levels.
        input  wire                          i_irq,
        input  wire                          i_fiq,

        // From fetch.
        input  wire arm_frontend_pkg::word_t i_instr,
        input  wire arm_frontend_pkg::word_t i_pc,
        input  wire                          i_valid,

        // To decode.
        output arm_frontend_pkg::word_t      o_instr,
        output arm_frontend_pkg::word_t      o_pc,
        output logic                         o_valid,

        // Back to fetch.
        output logic                         o_stall,

        // Interrupts, masked while a BL is in flight.
        output logic                         o_irq,
        output logic                         o_fiq
);

        import arm_frontend_pkg::*;

        bl_state_t state_ff;
        bl_state_t state_nxt;

        // Current word is a branch with link.
        logic  is_bl;
        // Link write for this BL.
        word_t link_instr;
        // Same branch, link bit cleared.
        word_t plain_branch;

        assign is_bl = (i_instr[27:25] == CLASS_BRANCH_BITS) && i_instr[LINK_BIT];

        // Offset depends on how far ahead the PC reads in each state.
        assign link_instr = {i_instr[31:28],
                             i_cpsr[CPSR_T] ? BL_LINK_THUMB : BL_LINK_ARM};

        always_comb
        begin
                plain_branch           = i_instr;
                plain_branch[LINK_BIT] = 1'b0;
        end

        // Data path, no register in it.
        always_comb
        begin
                // Pass through by default.
                o_instr   = i_instr;
                o_pc      = i_pc;
                o_valid   = i_valid;
                o_stall   = 1'b0;
                o_irq     = i_irq;
                o_fiq     = i_fiq;
                state_nxt = BL_IDLE;

                if (i_valid)
                begin
                        case (state_ff)
                        BL_IDLE:
                        begin
                                if (is_bl)
                                begin
                                        // Send the link write first.
                                        o_instr   = link_instr;
                                        // Keep fetch on this BL for one more cycle.
                                        o_stall   = 1'b1;
                                        o_irq     = 1'b0;
                                        o_fiq     = 1'b0;
                                        state_nxt = BL_BRANCH;
                                end
                        end
                        BL_BRANCH:
                        begin
                                // Fetch is frozen, so this is still the BL.
                                o_instr = plain_branch;
                                // No interrupt between the two halves.
                                o_irq   = 1'b0;
                                o_fiq   = 1'b0;
                        end
                        default:
                        begin
                                state_nxt = BL_IDLE;
                        end
                        endcase
                end
        end

        // State moves only on unstalled edges.
        // A clear abandons a half-done BL.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                        state_ff <= BL_IDLE;
                else if (!i_stall)
                        state_ff <= state_nxt;
        end

        // The second half must follow a real BL.
        a_branch_from_bl : assert property (
                @(posedge i_clk) disable iff (i_reset)
                (state_ff == BL_BRANCH) && ($past(state_ff) == BL_IDLE)
                |-> $past(i_valid && is_bl)
        );

        // Stalling fetch only makes sense with a word in hand.
        a_stall_valid : assert property (
                @(posedge i_clk) disable iff (i_reset)
                o_stall |-> o_valid
        );

endmodule

`default_nettype wire

//--- hdl/arm_decode.sv
`default_nettype none

module arm_decode (
        // Clock and reset.
        input  wire                           i_clk,
        input  wire                           i_reset,

        // Downstream control.
        input  wire                           i_clear,
        input  wire                           i_stall,

        // From the BL split.
        input  wire arm_frontend_pkg::word_t  i_instr,
        input  wire arm_frontend_pkg::word_t  i_pc,
        input  wire                           i_valid,
        input  wire                           i_irq,
        input  wire                           i_fiq,

        // Decoded fields for issue.
        output logic                          o_dec_valid,
        output arm_frontend_pkg::word_t       o_dec_pc,
        output arm_frontend_pkg::cond_t       o_dec_cond,
        output arm_frontend_pkg::instr_class_t o_dec_class,
        output arm_frontend_pkg::opcode_t     o_dec_opcode,
        output logic                          o_dec_set_flags,
        output arm_frontend_pkg::reg_idx_t    o_dec_rd,
        output arm_frontend_pkg::reg_idx_t    o_dec_rn,
        output arm_frontend_pkg::word_t       o_dec_imm,
        output arm_frontend_pkg::offset_t     o_dec_branch_offset,
        output logic                          o_dec_irq,
        output logic                          o_dec_fiq
);

        import arm_frontend_pkg::*;

        instr_class_t class_nxt;
        word_t        imm_nxt;
        offset_t      offset_nxt;

        // Zero extended 8-bit immediate.
        word_t        imm8;
        // Rotate amount is twice the 4-bit field.
        logic [4:0]   rot;
        // Immediate doubled up so a right shift gives a rotate.
        logic [63:0]  imm_pair;
        logic [63:0]  imm_shifted;

        // Class from bits 27 to 25.
        always_comb
        begin
                casez (i_instr[27:25])
                3'b00?:            class_nxt = DATA_PROC;
                3'b01?:            class_nxt = LOAD_STORE;
                CLASS_BRANCH_BITS: class_nxt = BRANCH;
                default:           class_nxt = OTHER;
                endcase
        end

        // Rotated immediate.
        assign imm8        = {24'd0, i_instr[7:0]};
        assign rot         = {i_instr[11:8], 1'b0};
        assign imm_pair    = {imm8, imm8};
        assign imm_shifted = imm_pair >> rot;

        // Only an immediate operand form has one.
        assign imm_nxt = i_instr[25] ? imm_shifted[31:0] : '0;

        // Word offset to bytes with the sign kept.
        assign offset_nxt = (class_nxt == BRANCH) ?
                            {{6{i_instr[23]}}, i_instr[23:0], 2'b00} : '0;

        // Valid and interrupts.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_dec_valid <= 1'b0;
                        o_dec_irq   <= 1'b0;
                        o_dec_fiq   <= 1'b0;
                end
                else if (i_clear)
                begin
                        o_dec_valid <= 1'b0;
                end
                else if (!i_stall)
                begin
                        o_dec_valid <= i_valid;
                        // Interrupts travel with the instruction.
                        if (i_valid)
                        begin
                                o_dec_irq <= i_irq;
                                o_dec_fiq <= i_fiq;
                        end
                end
        end

        // Fields.
        // Loaded only from a valid word on an unstalled edge.
        always_ff @(posedge i_clk)
        begin
                if (!i_stall && i_valid)
                begin
                        o_dec_pc            <= i_pc;
                        o_dec_cond          <= i_instr[31:28];
                        o_dec_class         <= class_nxt;
                        o_dec_opcode        <= i_instr[24:21];
                        o_dec_set_flags     <= i_instr[20];
                        o_dec_rn            <= i_instr[19:16];
                        o_dec_rd            <= i_instr[15:12];
                        o_dec_imm           <= imm_nxt;
                        o_dec_branch_offset <= offset_nxt;
                end
        end

endmodule

`default_nettype wire

//--- hdl/arm_fetch.sv
`default_nettype none

module arm_fetch (
        // Clock and reset.
        input  wire                         i_clk,
        input  wire                         i_reset,

        // Redirect from writeback.
        input  wire                         i_clear,
        input  wire arm_frontend_pkg::word_t i_clear_pc,

        // Stall from issue and from the BL split.
        input  wire                         i_stall,
        input  wire                         i_split_stall,

        // Instruction memory, read in the same cycle.
        output arm_frontend_pkg::word_t     o_imem_addr,
        input  wire arm_frontend_pkg::word_t i_imem_rdata,

        // Fetched instruction towards the BL split.
        output arm_frontend_pkg::word_t     o_instr,
        output arm_frontend_pkg::word_t     o_pc,
        output logic                        o_valid
);

        import arm_frontend_pkg::*;

        // Address of the word being read now.
        word_t pc_ff;
        // High on edges where fetch may move on.
        logic  advance;

        // Either stall freezes the whole stage.
        assign advance = !(i_stall || i_split_stall);

        // The memory sees the PC directly.
        assign o_imem_addr = pc_ff;

        // PC and valid.
        // Clear is checked before the stalls so a redirect is never lost.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        pc_ff   <= RESET_PC;
                        o_valid <= 1'b0;
                end
                else if (i_clear)
                begin
                        // Jump to the new path, drop the stale word.
                        pc_ff   <= i_clear_pc;
                        o_valid <= 1'b0;
                end
                else if (advance)
                begin
                        pc_ff   <= pc_ff + WORD_BYTES;
                        o_valid <= 1'b1;
                end
        end

        // Captured word and its address.
        // Held as long as either stall is up.
        always_ff @(posedge i_clk)
        begin
                if (advance)
                begin
                        o_instr <= i_imem_rdata;
                        o_pc    <= pc_ff;
                end
        end

        // Fetch only ever steps by a word.
        // A misaligned PC means a bad redirect target.
        a_pc_aligned : assert property (
                @(posedge i_clk) disable iff (i_reset)
                pc_ff[1:0] == 2'b00
        );

endmodule

`default_nettype wire

//--- hdl/arm_frontend.sv
`default_nettype none

module arm_frontend (
        input  wire                            i_clk,
        input  wire                            i_reset,

        // Instruction memory.
        output wire arm_frontend_pkg::word_t   o_imem_addr,
        input  wire arm_frontend_pkg::word_t   i_imem_rdata,

        // Interrupts and status.
        input  wire                            i_irq,
        input  wire                            i_fiq,
        input  wire arm_frontend_pkg::word_t   i_cpsr,

        // Clear beats stall.
        input  wire                            i_clear,
        input  wire arm_frontend_pkg::word_t   i_clear_pc,
        input  wire                            i_stall,

        // Decode outputs.
        output wire                            o_dec_valid,
        output wire arm_frontend_pkg::word_t   o_dec_pc,
        output wire arm_frontend_pkg::cond_t   o_dec_cond,
        output wire arm_frontend_pkg::instr_class_t o_dec_class,
        output wire arm_frontend_pkg::opcode_t o_dec_opcode,
        output wire                            o_dec_set_flags,
        output wire arm_frontend_pkg::reg_idx_t o_dec_rd,
        output wire arm_frontend_pkg::reg_idx_t o_dec_rn,
        output wire arm_frontend_pkg::word_t   o_dec_imm,
        output wire arm_frontend_pkg::offset_t o_dec_branch_offset,
        output wire                            o_dec_irq,
        output wire                            o_dec_fiq
);

        import arm_frontend_pkg::*;

        // Fetch to BL split.
        word_t fetch_instr;
        word_t fetch_pc;
        logic  fetch_valid;

        // BL split to decode.
        word_t split_instr;
        word_t split_pc;
        logic  split_valid;
        logic  split_irq;
        logic  split_fiq;

        // BL split back to fetch.
        logic  split_stall;

        arm_fetch u_fetch (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_clear       (i_clear),
                .i_clear_pc    (i_clear_pc),
                .i_stall       (i_stall),
                .i_split_stall (split_stall),
                .o_imem_addr   (o_imem_addr),
                .i_imem_rdata  (i_imem_rdata),
                .o_instr       (fetch_instr),
                .o_pc          (fetch_pc),
                .o_valid       (fetch_valid)
        );

        arm_bl_split u_bl_split (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_clear (i_clear),
                .i_stall (i_stall),
                .i_cpsr  (i_cpsr),
                .i_irq   (i_irq),
                .i_fiq   (i_fiq),
                .i_instr (fetch_instr),
                .i_pc    (fetch_pc),
                .i_valid (fetch_valid),
                .o_instr (split_instr),
                .o_pc    (split_pc),
                .o_valid (split_valid),
                .o_stall (split_stall),
                .o_irq   (split_irq),
                .o_fiq   (split_fiq)
        );

        arm_decode u_decode (
                .i_clk               (i_clk),
                .i_reset             (i_reset),
                .i_clear             (i_clear),
                .i_stall             (i_stall),
                .i_instr             (split_instr),
                .i_pc                (split_pc),
                .i_valid             (split_valid),
                .i_irq               (split_irq),
                .i_fiq               (split_fiq),
                .o_dec_valid         (o_dec_valid),
                .o_dec_pc            (o_dec_pc),
                .o_dec_cond          (o_dec_cond),
                .o_dec_class         (o_dec_class),
                .o_dec_opcode        (o_dec_opcode),
                .o_dec_set_flags     (o_dec_set_flags),
                .o_dec_rd            (o_dec_rd),
                .o_dec_rn            (o_dec_rn),
                .o_dec_imm           (o_dec_imm),
                .o_dec_branch_offset (o_dec_branch_offset),
                .o_dec_irq           (o_dec_irq),
                .o_dec_fiq           (o_dec_fiq)
        );

endmodule

`default_nettype wire

//--- hdl/arm_frontend_pkg.sv
`default_nettype none

package arm_frontend_pkg;

        // Basic widths.
        localparam int WORD_W    = 32;
        localparam int COND_W    = 4;
        localparam int REG_IDX_W = 4;
        localparam int OPCODE_W  = 4;

        // Instruction and address word.
        typedef logic [WORD_W-1:0]    word_t;
        // Condition field, bits 31 to 28.
        typedef logic [COND_W-1:0]    cond_t;
        // Register index.
        typedef logic [REG_IDX_W-1:0] reg_idx_t;
        // Data processing opcode.
        typedef logic [OPCODE_W-1:0]  opcode_t;
        // Branch offset in bytes, already sign extended.
        typedef logic [WORD_W-1:0]    offset_t;

        // Coarse instruction class from bits 27 to 25.
        typedef enum logic [1:0] {
                DATA_PROC,
                LOAD_STORE,
                BRANCH,
                OTHER
        } instr_class_t;

        // States of the BL split machine.
        typedef enum logic {
                BL_IDLE,
                BL_BRANCH
        } bl_state_t;

        // Fetch restarts here after reset.
        localparam word_t RESET_PC   = '0;
        // Fetch step, one word.
        localparam word_t WORD_BYTES = 32'd4;

        // Class field of B and BL.
        localparam logic [2:0] CLASS_BRANCH_BITS = 3'b101;

        // SUB LR, PC, #4 without its condition.
        localparam logic [27:0] BL_LINK_ARM   = 28'h24FE004;
        // SUB LR, PC, #1, keeps LR bit 0 set in Thumb state.
        localparam logic [27:0] BL_LINK_THUMB = 28'h24FE001;

        // Link bit of a branch.
        localparam int LINK_BIT = 24;
        // Thumb flag in the status word.
        localparam int CPSR_T   = 5;

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the front end with its testbench, runs it and scans the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
        --top-module tb_arm_frontend \
        -f arm_frontend.f \
        -o sim_arm_frontend \
        || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_arm_frontend > sim.log 2>&1 \
        || { cat sim.log; echo "Simulation exited abnormally"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1
exit 0

//--- tb/tb_arm_frontend.sv
`default_nettype none

module tb_arm_frontend;

        import arm_frontend_pkg::*;

        // Longest wait in clock cycles.
        localparam int TIMEOUT = 200;
        localparam logic [15:0] LFSR_SEED = 16'd98;

        // Decode outputs other than valid packed in port order.
        typedef logic [116:0] rec_t;

        logic         i_clk;
        logic         i_reset;
        word_t        o_imem_addr;
        word_t        i_imem_rdata;
        logic         i_irq;
        logic         i_fiq;
        word_t        i_cpsr;
        logic         i_clear;
        word_t        i_clear_pc;
        logic         i_stall;
        logic         o_dec_valid;
        word_t        o_dec_pc;
        cond_t        o_dec_cond;
        instr_class_t o_dec_class;
        opcode_t      o_dec_opcode;
        logic         o_dec_set_flags;
        reg_idx_t     o_dec_rd;
        reg_idx_t     o_dec_rn;
        word_t        o_dec_imm;
        offset_t      o_dec_branch_offset;
        logic         o_dec_irq;
        logic         o_dec_fiq;

        // Instruction memory model.
        word_t imem [0:63];

        // Collected and expected decode outputs.
        rec_t got_q[$];
        rec_t exp_q[$];
        // First collected entry that belongs to the current test.
        int   got_base;
        // Stall seen at the previous edge marks a held output.
        logic stall_q = 1'b0;

        logic [15:0] lfsr_state;
        int          test_errors;
        int          total_errors;
        int          tests_run;
        int          tests_failed;

        arm_frontend dut (.*);

        // Memory answers in the same cycle.
        assign i_imem_rdata = imem[o_imem_addr[7:2]];

        initial
        begin
                i_clk = 1'b0;
                forever
                        #2 i_clk = ~i_clk;
        end

        function automatic rec_t pack_rec(input word_t pc, input cond_t cond,
                                          input logic [1:0] cls, input opcode_t opc,
                                          input logic sf, input reg_idx_t rd,
                                          input reg_idx_t rn, input word_t imm,
                                          input word_t off, input logic irq, input logic fiq);
                return {pc, cond, cls, opc, sf, rd, rn, imm, off, irq, fiq};
        endfunction

        // Snapshot of what decode shows right now.
        function automatic rec_t current_rec();
                return pack_rec(o_dec_pc, o_dec_cond, o_dec_class, o_dec_opcode,
                                o_dec_set_flags, o_dec_rd, o_dec_rn, o_dec_imm,
                                o_dec_branch_offset, o_dec_irq, o_dec_fiq);
        endfunction

        // Collects new outputs and skips held ones.
        always @(posedge i_clk)
        begin
                if (o_dec_valid && !stall_q)
                        got_q.push_back(current_rec());
                stall_q <= i_stall;
        end

        // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
        function automatic logic [15:0] lfsr_step(input logic [15:0] s);
                logic fb;
                fb = s[15] ^ s[13] ^ s[12] ^ s[10];
                return {s[14:0], fb};
        endfunction

        // One step per bit taken.
        function automatic word_t rand_bits(input int n);
                word_t v;
                int    k;
                v = '0;
                for (k = 0; k < n; k++)
                begin
                        lfsr_state = lfsr_step(lfsr_state);
                        v = {v[30:0], lfsr_state[0]};
                end
                return v;
        endfunction

        function automatic logic is_bl_word(input word_t w);
                return (w[27:25] == 3'b101) && w[24];
        endfunction

        // Random condition and offset with the link bit set.
        function automatic word_t bl_word();
                word_t w;
                w = rand_bits(32);
                w[27:24] = 4'b1011;
                return w;
        endfunction

        // Field split straight from the ARM encoding.
        function automatic rec_t ref_decode(input word_t w, input word_t pc, input logic irq);
                logic [1:0] cls;
                word_t      imm;
                word_t      off;
                int         k;
                case (w[27:25])
                3'b000, 3'b001: cls = DATA_PROC;
                3'b010, 3'b011: cls = LOAD_STORE;
                3'b101:         cls = BRANCH;
                default:        cls = OTHER;
                endcase
                // Rotate right one bit at a time.
                imm = '0;
                if (w[25])
                begin
                        imm = {24'd0, w[7:0]};
                        for (k = 0; k < 2 * int'(w[11:8]); k++)
                                imm = {imm[0], imm[31:1]};
                end
                off = '0;
                if (w[27:25] == 3'b101)
                        off = {{8{w[23]}}, w[23:0]} << 2;
                return pack_rec(pc, w[31:28], cls, w[24:21], w[20], w[15:12], w[19:16],
                                imm, off, irq, irq);
        endfunction

        // SUB LR, PC, #4 in ARM state and #1 in Thumb state.
        function automatic rec_t link_rec(input word_t w, input word_t pc, input logic t_bit);
                word_t imm;
                imm = t_bit ? 32'd1 : 32'd4;
                return pack_rec(pc, w[31:28], DATA_PROC, 4'b0010, 1'b0, 4'd14, 4'd15,
                                imm, '0, 1'b0, 1'b0);
        endfunction

        // Walks the program from start.
        // A BL gives two masked entries.
        task automatic build_expected(input word_t start, input int n,
                                      input logic t_bit, input logic irq);
                word_t addr;
                word_t w;
                addr = start;
                exp_q.delete();
                while (exp_q.size() < n)
                begin
                        w = imem[addr[7:2]];
                        if (is_bl_word(w))
                        begin
                                exp_q.push_back(link_rec(w, addr, t_bit));
                                w[24] = 1'b0;
                                exp_q.push_back(ref_decode(w, addr, 1'b0));
                        end
                        else
                        begin
                                exp_q.push_back(ref_decode(w, addr, irq));
                        end
                        addr = addr + 32'd4;
                end
        endtask

        // Data processing words with load/store mixed in on request.
        task automatic fill_program(input logic mixed);
                word_t w;
                int    k;
                for (k = 0; k < 64; k++)
                begin
                        w = rand_bits(32);
                        w[27] = 1'b0;
                        if (!mixed)
                                w[26] = 1'b0;
                        imem[k] = w;
                end
        endtask

        // Eight cycles of reset before collection starts afresh.
        task automatic apply_reset(input logic t_bit, input logic irq);
                word_t cpsr;
                int    k;
                cpsr = '0;
                cpsr[CPSR_T] = t_bit;
                @(posedge i_clk);
                i_reset <= 1'b1;
                i_clear <= 1'b0;
                i_stall <= 1'b0;
                i_irq   <= irq;
                i_fiq   <= irq;
                i_cpsr  <= cpsr;
                for (k = 0; k < 8; k++)
                        @(posedge i_clk);
                i_reset <= 1'b0;
                @(negedge i_clk);
                got_base = got_q.size();
        endtask

        task automatic wait_outputs(input string name, input int n);
                int cycles;
                cycles = 0;
                while (got_q.size() - got_base < n && cycles < TIMEOUT)
                begin
                        @(negedge i_clk);
                        cycles++;
                end
                if (got_q.size() - got_base < n)
                begin
                        $display("%s: timed out after %0d cycles with %0d of %0d decode outputs",
                                 name, cycles, got_q.size() - got_base, n);
                        test_errors++;
                end
        endtask

        task automatic check_outputs(input string name);
                int k;
                for (k = 0; k < exp_q.size(); k++)
                begin
                        if (got_base + k < got_q.size())
                        begin
                                if (got_q[got_base + k] !== exp_q[k])
                                begin
                                        $display("Mismatch %s output %0d: expected %h, actual %h",
                                                 name, k, exp_q[k], got_q[got_base + k]);
                                        test_errors++;
                                end
                        end
                end
        endtask

        task automatic finish_test(input string name);
                tests_run++;
                total_errors += test_errors;
                if (test_errors != 0)
                        tests_failed++;
                $display("%s done, %0d errors", name, test_errors);
                test_errors = 0;
        endtask

        // Decode is empty after reset and starts at address zero.
        task automatic reset_start();
                int k;
                for (k = 0; k < 64; k++)
                        imem[k] = 32'hE3A0_0000 + word_t'(k * 4);
                apply_reset(1'b0, 1'b0);
                if (o_dec_valid !== 1'b0)
                begin
                        $display("reset: o_dec_valid is high right after reset");
                        test_errors++;
                end
                build_expected(RESET_PC, 1, 1'b0, 1'b0);
                wait_outputs("reset", exp_q.size());
                check_outputs("reset");
                finish_test("reset");
        endtask

        task automatic data_sequence();
                fill_program(1'b1);
                build_expected(RESET_PC, 16, 1'b0, 1'b0);
                apply_reset(1'b0, 1'b0);
                wait_outputs("sequence", exp_q.size());
                check_outputs("sequence");
                finish_test("sequence");
        endtask

        // One lone BL and a back to back pair.
        task automatic bl_split_run(input string name, input logic t_bit, input logic irq);
                fill_program(1'b1);
                imem[2] = bl_word();
                imem[5] = bl_word();
                imem[6] = bl_word();
                build_expected(RESET_PC, 14, t_bit, irq);
                apply_reset(t_bit, irq);
                wait_outputs(name, exp_q.size());
                check_outputs(name);
                finish_test(name);
        endtask

        // Redirect to 40 with or without the split holding fetch on a BL.
        task automatic clear_redirect(input string name, input logic mid_bl);
                int cycles;
                cycles = 0;
                fill_program(1'b0);
                if (mid_bl)
                        imem[4] = bl_word();
                apply_reset(1'b0, 1'b0);
                if (mid_bl)
                begin
                        // Fetch takes the BL at 16 on the next edge.
                        while (o_imem_addr !== 32'd16 && cycles < TIMEOUT)
                        begin
                                @(negedge i_clk);
                                cycles++;
                        end
                        if (o_imem_addr !== 32'd16)
                        begin
                                $display("%s: fetch never reached the BL", name);
                                test_errors++;
                        end
                end
                else
                begin
                        wait_outputs(name, 3);
                end
                @(posedge i_clk);
                i_clear    <= 1'b1;
                i_clear_pc <= 32'd40;
                @(negedge i_clk);
                // The clear meets the split holding fetch on the BL.
                if (mid_bl && dut.split_stall !== 1'b1)
                begin
                        $display("%s: the clear missed the BL stall", name);
                        test_errors++;
                end
                @(posedge i_clk);
                i_clear <= 1'b0;
                @(negedge i_clk);
                // Anything collected up to here is the old path.
                got_base = got_q.size();
                build_expected(32'd40, 6, 1'b0, 1'b0);
                wait_outputs(name, exp_q.size());
                check_outputs(name);
                finish_test(name);
        endtask

        // Outputs stay frozen over ten stalled edges before the run goes on.
        task automatic stall_hold();
                rec_t snap;
                logic snap_valid;
                int   k;
                fill_program(1'b1);
                build_expected(RESET_PC, 14, 1'b0, 1'b0);
                apply_reset(1'b0, 1'b0);
                wait_outputs("stall", 3);
                @(posedge i_clk);
                i_stall <= 1'b1;
                @(negedge i_clk);
                snap       = current_rec();
                snap_valid = o_dec_valid;
                for (k = 1; k <= 10; k++)
                begin
                        @(posedge i_clk);
                        if (k == 10)
                                i_stall <= 1'b0;
                        @(negedge i_clk);
                        if (o_dec_valid !== snap_valid || current_rec() !== snap)
                        begin
                                $display("Mismatch stall cycle %0d: expected %h, actual %h",
                                         k, snap, current_rec());
                                test_errors++;
                        end
                end
                wait_outputs("stall", exp_q.size());
                check_outputs("stall");
                finish_test("stall");
        endtask

        initial
        begin
                i_reset      = 1'b1;
                i_irq        = 1'b0;
                i_fiq        = 1'b0;
                i_cpsr       = '0;
                i_clear      = 1'b0;
                i_clear_pc   = '0;
                i_stall      = 1'b0;
                lfsr_state   = LFSR_SEED;
                got_base     = 0;
                test_errors  = 0;
                total_errors = 0;
                tests_run    = 0;
                tests_failed = 0;

                reset_start();
                data_sequence();
                bl_split_run("bl_arm", 1'b0, 1'b0);
                bl_split_run("bl_thumb", 1'b1, 1'b0);
                bl_split_run("bl_irq", 1'b0, 1'b1);
                clear_redirect("clear", 1'b0);
                clear_redirect("clear_mid_bl", 1'b1);
                stall_hold();

                $display("Tests run %0d, failed %0d, errors %0d",
                         tests_run, tests_failed, total_errors);
                if (total_errors == 0)
                        $display("All tests passed!");
                else
                        $display("Test failures found");
                $finish;
        end

endmodule

`default_nettype wire
